// File: build.f
design/acq_pkg.sv
design/serial_pkg.sv
design/sample_sequencer.sv
design/serial_tx_lane.sv
design/link_status_collector.sv
design/acq_link_top.sv
tb/acq_link_props.sv
tb/acq_link_tb.sv

// File: Makefile
# Verilator build and run for the acquisition link testbench
# run from the project root so the golden file path resolves

VERILATOR ?= verilator
TOP       ?= acq_link_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := *** PASSED ***
FAIL_MSG  := *** FAILED ***
SOURCES   := $(wildcard design/*.sv tb/*.sv) tb/acq_link_golden.txt

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "RESULT: PASS"; \
	else \
		echo "RESULT: FAIL, simulation stopped early"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/acq_link_golden.txt
// columns in hex: adc delay (clocks soc to eoc), data byte, dsr mask, channel, outcome
// outcome 00 sent, 01 overrun, 02 no_dsr; a line with outcome ff closes the list
14 a5 f 0 00
14 3c f 1 00
14 f0 f 2 00
14 0f f 3 00
14 81 f 4 00
02 55 f 5 01
1e 66 b 6 02
1e 99 f 7 00
1e 12 f 0 00
1e 34 f 1 00
1e de f 2 00
1e ad 7 3 02
1e c3 f 4 00
01 5a f 5 00
01 77 b 6 01
01 e1 f 7 00
00 00 f 0 ff

// File: tb/acq_link_tb.sv
/*
 * Testbench for the acquisition link. Plays the ADC from the golden file,
 * decodes every serial lane at mid-bit and checks channels, bytes, flags
 * and the frame count. Run from the project root.
 */

`timescale 1ns/100ps

module acq_link_tb;
	import acq_pkg::*;
	import serial_pkg::*;

	// golden line: delay, data, dsr mask, channel, outcome
	localparam int fields        = 5;
	localparam int max_vectors   = 32;
	localparam int soc_timeout   = 20;
	localparam int drain_timeout = 4 * frame_bits * bit_cycles;
	localparam int rx_idle_limit = 4000;
	localparam logic [7:0] outcome_sent    = 8'h00;
	localparam logic [7:0] outcome_overrun = 8'h01;
	localparam logic [7:0] outcome_no_dsr  = 8'h02;
	// outcome value of the closing line
	localparam logic [7:0] outcome_end     = 8'hff;

	logic       clock;
	logic       rst_n;
	logic       run;
	logic       eoc;
	logic [7:0] adc_data;
	logic       soc;
	logic       mux_en;
	channel_t   channel;
	lane_mask_t dsr;
	lane_mask_t data_out;
	logic [15:0] frames_sent;
	lane_mask_t overrun_flags;
	lane_mask_t dsr_flags;

	logic [7:0] golden_mem [0:max_vectors*fields-1];
	// bytes still owed by each lane, oldest first
	logic [7:0] expected_q [num_lanes][$];
	int         num_vectors;
	int         sent_total;
	lane_mask_t exp_overrun;
	lane_mask_t exp_dsr;
	logic       run_passed;
	logic       fail_reported;

	acq_link_top u_acq_link_top (
		.clock         (clock),
		.rst_n         (rst_n),
		.run           (run),
		.eoc           (eoc),
		.adc_data      (adc_data),
		.soc           (soc),
		.mux_en        (mux_en),
		.channel       (channel),
		.dsr           (dsr),
		.data_out      (data_out),
		.frames_sent   (frames_sent),
		.overrun_flags (overrun_flags),
		.dsr_flags     (dsr_flags)
	);

	bind acq_link_top acq_link_props u_acq_link_props (
		.clock       (clock),
		.rst_n       (rst_n),
		.soc         (soc),
		.mux_en      (mux_en),
		.lane_load   (lane_load),
		.dsr         (dsr),
		.data_out    (data_out),
		.lane_status (lane_status)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		fail_reported = 1'b1;
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_channel(input channel_t got, input channel_t exp, input string name);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string name);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_mask(input lane_mask_t got, input lane_mask_t exp, input string name);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string name);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic load_golden();
		$readmemh("tb/acq_link_golden.txt", golden_mem);
		num_vectors = 0;
		// count lines up to the closing marker
		while (num_vectors < max_vectors &&
			golden_mem[num_vectors*fields+4] !== outcome_end) begin
			num_vectors++;
		end
		if (num_vectors == 0 || num_vectors == max_vectors) begin
			stop_with_error("golden file is missing, empty or has no closing line");
		end
	endtask

	// nothing may move before run goes high
	task automatic check_reset_state();
		if (soc !== 1'b0 || mux_en !== 1'b0) begin
			stop_with_error("soc or mux_en active while run is low");
		end
		check_mask(data_out, '1, "data_out");
		check_count(frames_sent, 16'h0000, "frames_sent");
		check_mask(overrun_flags, '0, "overrun_flags");
		check_mask(dsr_flags, '0, "dsr_flags");
	endtask

	task automatic wait_for_soc();
		int waited;
		waited = 0;
		while (soc !== 1'b1) begin
			@(negedge clock);
			waited++;
			if (waited > soc_timeout) begin
				stop_with_error($sformatf("no soc within %0d clocks", soc_timeout));
			end
		end
	endtask

	// ADC answer: eoc and byte together, dsr mask applied for the load
	task automatic convert(input int delay, input logic [7:0] data, input lane_mask_t mask,
		input logic last);
		repeat (delay) @(negedge clock);
		eoc      = 1'b1;
		adc_data = data;
		dsr      = mask;
		// sequencer goes idle after this dispatch
		if (last) begin
			run = 1'b0;
		end
		@(negedge clock);
		eoc = 1'b0;
	endtask

	function automatic int queued_frames();
		int total;
		total = 0;
		for (int i = 0; i < num_lanes; i++) begin
			total += expected_q[i].size();
		end
		return total;
	endfunction

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (queued_frames() != 0) begin
			@(negedge clock);
			waited++;
			if (waited > drain_timeout) begin
				stop_with_error($sformatf("%0d frames never arrived", queued_frames()));
			end
		end
	endtask

	initial begin : main_seq
		int         lane;
		logic [7:0] delay;
		logic [7:0] data;
		logic [7:0] mask8;
		logic [7:0] exp_ch;
		logic [7:0] outcome;
		rst_n         = 1'b0;
		run           = 1'b0;
		eoc           = 1'b0;
		adc_data      = '0;
		dsr           = '1;
		run_passed    = 1'b0;
		fail_reported = 1'b0;
		sent_total    = 0;
		exp_overrun   = '0;
		exp_dsr       = '0;
		load_golden();
		repeat (5) @(negedge clock);
		rst_n = 1'b1;
		repeat (12) begin
			@(negedge clock);
			check_reset_state();
		end
		run = 1'b1;
		for (int k = 0; k < num_vectors; k++) begin
			delay   = golden_mem[k*fields+0];
			data    = golden_mem[k*fields+1];
			mask8   = golden_mem[k*fields+2];
			exp_ch  = golden_mem[k*fields+3];
			outcome = golden_mem[k*fields+4];
			wait_for_soc();
			if (mux_en !== 1'b1) begin
				stop_with_error("soc raised while mux_en was low");
			end
			check_channel(channel, channel_t'(exp_ch), "channel");
			// flags from the previous conversion have settled by now
			check_mask(overrun_flags, exp_overrun, "overrun_flags");
			check_mask(dsr_flags, exp_dsr, "dsr_flags");
			lane = int'(exp_ch) % num_lanes;
			case (outcome)
				outcome_sent: begin
					expected_q[lane].push_back(data);
					sent_total++;
				end
				outcome_overrun: exp_overrun[lane] = 1'b1;
				outcome_no_dsr:  exp_dsr[lane] = 1'b1;
				default: stop_with_error($sformatf("golden line %0d has an unknown outcome", k));
			endcase
			convert(int'(delay), data, lane_mask_t'(mask8), k == num_vectors - 1);
		end
		wait_for_drain();
		// last decode is mid stop bit, count follows the frame end
		repeat (bit_cycles) @(negedge clock);
		check_count(frames_sent, 16'(sent_total), "frames_sent");
		check_mask(overrun_flags, exp_overrun, "overrun_flags");
		check_mask(dsr_flags, exp_dsr, "dsr_flags");
		check_mask(data_out, '1, "data_out");
		run_passed = 1'b1;
		$display("*** PASSED ***");
		$finish;
	end

	// one decoder per lane, samples each bit near its middle
	for (genvar g = 0; g < num_lanes; g++) begin : g_rx
		initial begin : rx_proc
			logic [7:0] rx_byte;
			int         idle;
			rx_byte = '0;
			forever begin
				idle = 0;
				while (rst_n !== 1'b1 || data_out[g] !== 1'b0) begin
					@(negedge clock);
					idle++;
					if (idle > rx_idle_limit) begin
						stop_with_error($sformatf("lane %0d idle for %0d clocks", g, idle));
					end
				end
				// start edge seen half a clock in, move to mid bit
				repeat (bit_cycles / 2 - 1) @(negedge clock);
				if (data_out[g] !== 1'b0) begin
					stop_with_error($sformatf("lane %0d start bit shorter than a bit time", g));
				end
				// MSB first
				for (int b = 0; b < 8; b++) begin
					repeat (bit_cycles) @(negedge clock);
					rx_byte = {rx_byte[6:0], data_out[g]};
				end
				repeat (bit_cycles) @(negedge clock);
				if (data_out[g] !== 1'b1) begin
					stop_with_error($sformatf("lane %0d stop bit is low", g));
				end
				if (expected_q[g].size() == 0) begin
					stop_with_error($sformatf("lane %0d sent a frame with no sample routed", g));
				end else begin
					check_byte(rx_byte, expected_q[g].pop_front(), $sformatf("data_out[%0d]", g));
				end
			end
		end
	end

	// run cut short, for example by a failing assertion
	final begin
		if (!run_passed && !fail_reported) begin
			$display("*** FAILED ***");
		end
	end

endmodule

// File: tb/acq_link_props.sv
/*
 * Concurrent checks on the acquisition link top level, bound in from the
 * testbench. Covers the soc strobe, the lane load decode and idle lines.
 */

`timescale 1ns/100ps

module acq_link_props (
	input logic                                                 clock,
	input logic                                                 rst_n,
	input logic                                                 soc,
	input logic                                                 mux_en,
	input serial_pkg::lane_mask_t                               lane_load,
	input serial_pkg::lane_mask_t                               dsr,
	input serial_pkg::lane_mask_t                               data_out,
	input serial_pkg::lane_status_t [serial_pkg::num_lanes-1:0] lane_status
);
	import serial_pkg::*;

	// lanes with a frame in flight, rebuilt from load, dsr and frame_done
	lane_mask_t lane_active;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			lane_active <= '0;
		end else begin
			for (int i = 0; i < num_lanes; i++) begin
				// a load in the frame_done cycle is refused as overrun
				if (lane_status[i].frame_done) begin
					lane_active[i] <= 1'b0;
				end else if (lane_load[i] && dsr[i]) begin
					lane_active[i] <= 1'b1;
				end
			end
		end
	end

	a_soc_pulse: assert property (@(posedge clock) disable iff (!rst_n) soc |=> !soc)
		else $error("soc held high for more than one cycle");

	a_load_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(lane_load))
		else $error("lane_load has more than one bit set");

	a_soc_mux: assert property (@(posedge clock) disable iff (!rst_n) soc |-> mux_en)
		else $error("soc raised while mux_en is low");

	// idle lines rest at the stop level
	a_idle_high: assert property (@(posedge clock) disable iff (!rst_n)
		&(data_out | lane_active))
		else $error("data_out low on an idle lane");

endmodule

// File: design/acq_link_top.sv
/*
 * Acquisition link top level. Sequencer drives the ADC and mux, one
 * transmit lane per serial output, and a collector for frame count and
 * error flags. Instances and wiring only.
 */

`timescale 1ns/100ps

module acq_link_top (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   run,
	input  logic                   eoc,
	input  logic [7:0]             adc_data,
	output logic                   soc,
	output logic                   mux_en,
	output acq_pkg::channel_t      channel,
	input  serial_pkg::lane_mask_t dsr,
	output serial_pkg::lane_mask_t data_out,
	output logic [15:0]            frames_sent,
	output serial_pkg::lane_mask_t overrun_flags,
	output serial_pkg::lane_mask_t dsr_flags
);
	import acq_pkg::*;
	import serial_pkg::*;

	// captured byte, broadcast to every lane
	sample_t sample;
	// one-hot load, only the addressed lane reacts
	lane_mask_t lane_load;
	lane_status_t [num_lanes-1:0] lane_status;

	sample_sequencer u_sample_sequencer (
		.clock     (clock),
		.rst_n     (rst_n),
		.run       (run),
		.eoc       (eoc),
		.adc_data  (adc_data),
		.soc       (soc),
		.mux_en    (mux_en),
		.channel   (channel),
		.sample    (sample),
		.lane_load (lane_load)
	);

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		serial_tx_lane u_serial_tx_lane (
			.clock    (clock),
			.rst_n    (rst_n),
			.sample   (sample),
			.load     (lane_load[i]),
			.dsr      (dsr[i]),
			.data_out (data_out[i]),
			.status   (lane_status[i])
		);
	end

	link_status_collector u_link_status_collector (
		.clock         (clock),
		.rst_n         (rst_n),
		.status        (lane_status),
		.frames_sent   (frames_sent),
		.overrun_flags (overrun_flags),
		.dsr_flags     (dsr_flags)
	);

endmodule

// File: design/link_status_collector.sv
/*
 * Drains the per-lane status strobes every cycle. Counts finished frames
 * in a saturating 16-bit counter and keeps sticky overrun and dsr flags
 * per lane until reset.
 */

`timescale 1ns/100ps

module link_status_collector (
	input  logic                                                 clock,
	input  logic                                                 rst_n,
	input  serial_pkg::lane_status_t [serial_pkg::num_lanes-1:0] status,
	output logic [15:0]                                          frames_sent,
	output serial_pkg::lane_mask_t                               overrun_flags,
	output serial_pkg::lane_mask_t                               dsr_flags
);
	import serial_pkg::*;

	// frames finishing this cycle, lanes may end together
	logic [$clog2(num_lanes+1)-1:0] done_cnt;
	// one spare bit catches the carry for saturation
	logic [16:0] sum;
	lane_mask_t overrun_now;
	lane_mask_t dsr_now;

	always_comb begin
		done_cnt = '0;
		for (int i = 0; i < num_lanes; i++) begin
			done_cnt       = done_cnt + $bits(done_cnt)'(status[i].frame_done);
			overrun_now[i] = status[i].overrun;
			dsr_now[i]     = status[i].no_dsr;
		end
		sum = {1'b0, frames_sent} + 17'(done_cnt);
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			frames_sent   <= '0;
			overrun_flags <= '0;
			dsr_flags     <= '0;
		end else begin
			// hold at all ones once the count overflows
			if (sum[16]) begin
				frames_sent <= '1;
			end else begin
				frames_sent <= sum[15:0];
			end
			// flags only ever set, cleared by reset
			overrun_flags <= overrun_flags | overrun_now;
			dsr_flags     <= dsr_flags | dsr_now;
		end
	end

endmodule

// File: design/serial_tx_lane.sv
/*
 * One asynchronous serial transmitter. Takes a sample on its load strobe
 * and sends start bit, data MSB first and stop bit at bit_cycles clocks
 * per bit. Refused loads are reported as overrun or no_dsr strobes.
 */

`timescale 1ns/100ps

module serial_tx_lane (
	input  logic                     clock,
	input  logic                     rst_n,
	input  acq_pkg::sample_t         sample,
	input  logic                     load,
	input  logic                     dsr,
	output logic                     data_out,
	output serial_pkg::lane_status_t status
);
	import serial_pkg::*;

	// frame in flight
	logic busy;
	// outgoing frame, bit frame_bits-1 is on the line
	logic [frame_bits-1:0] shift_q;
	// index of the bit being sent, 0 is the start bit
	logic [$clog2(frame_bits)-1:0] bit_cnt;
	// clocks spent in the current bit
	logic [$clog2(bit_cycles)-1:0] cyc_cnt;
	logic bit_end;
	logic last_bit;
	logic accept;
	logic overrun_q;
	logic no_dsr_q;

	assign bit_end  = busy && (cyc_cnt == $bits(cyc_cnt)'(bit_cycles - 1));
	assign last_bit = (bit_cnt == $bits(bit_cnt)'(frame_bits - 1));
	// busy wins over a low dsr when both would refuse
	assign accept   = load && !busy && dsr;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			bit_cnt   <= '0;
			cyc_cnt   <= '0;
			shift_q   <= '1;
			overrun_q <= 1'b0;
			no_dsr_q  <= 1'b0;
		end else begin
			if (accept) begin
				busy    <= 1'b1;
				bit_cnt <= '0;
				cyc_cnt <= '0;
				// start bit goes out on the next clock
				shift_q <= {1'b0, sample.data, 1'b1};
			end else if (busy) begin
				if (bit_end) begin
					cyc_cnt <= '0;
					// ones shift in, so the line is back high after the stop bit
					shift_q <= {shift_q[frame_bits-2:0], 1'b1};
					if (last_bit) begin
						busy <= 1'b0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end else begin
					cyc_cnt <= cyc_cnt + 1'b1;
				end
			end
			// refusal strobes, one cycle after the load
			overrun_q <= load && busy;
			no_dsr_q  <= load && !busy && !dsr;
		end
	end

	assign data_out = shift_q[frame_bits-1];

	// frame_done covers the last clock of the stop bit
	assign status = '{
		frame_done: bit_end && last_bit,
		overrun:    overrun_q,
		no_dsr:     no_dsr_q
	};

endmodule

// File: design/sample_sequencer.sv
/*
 * ADC and multiplexer control. Scans the channels in order, runs one
 * soc/eoc conversion per channel and hands each byte to a transmit lane
 * with a one-hot, single-cycle load strobe.
 */

`timescale 1ns/100ps

module sample_sequencer (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   run,
	input  logic                   eoc,
	input  logic [7:0]             adc_data,
	output logic                   soc,
	output logic                   mux_en,
	output acq_pkg::channel_t      channel,
	output acq_pkg::sample_t       sample,
	output serial_pkg::lane_mask_t lane_load
);
	import acq_pkg::*;
	import serial_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_settle,
		st_start,
		st_wait_eoc,
		st_dispatch
	} seq_state_t;

	seq_state_t state;
	logic [$clog2(mux_settle_cycles+1)-1:0] settle_cnt;
	// conversion result arrives this cycle
	logic take;

	// eoc may already come in the soc cycle when the ADC answers at once
	assign take = eoc && (state == st_start || state == st_wait_eoc);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			settle_cnt <= '0;
			soc        <= 1'b0;
			mux_en     <= 1'b0;
			channel    <= '0;
			lane_load  <= '0;
		end else begin
			// strobes default low
			soc       <= 1'b0;
			lane_load <= '0;
			case (state)
				st_idle: begin
					if (run) begin
						mux_en     <= 1'b1;
						settle_cnt <= '0;
						state      <= st_settle;
					end
				end
				st_settle: begin
					// mux has been enabled for mux_settle_cycles clocks at the end
					if (settle_cnt == $bits(settle_cnt)'(mux_settle_cycles - 1)) begin
						soc   <= 1'b1;
						state <= st_start;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				st_start: begin
					state <= st_wait_eoc;
				end
				st_wait_eoc: begin
					// conversion time is set by the ADC, no timeout here
					state <= st_wait_eoc;
				end
				st_dispatch: begin
					// next channel, wrap after the last mux input
					if (channel == channel_t'(num_channels - 1)) begin
						channel <= '0;
					end else begin
						channel <= channel + 1'b1;
					end
					if (run) begin
						mux_en     <= 1'b1;
						settle_cnt <= '0;
						state      <= st_settle;
					end else begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
			if (take) begin
				// lane is the low channel bits, strobe is one-hot
				lane_load <= lane_mask_t'(1) << channel[$clog2(num_lanes)-1:0];
				mux_en    <= 1'b0;
				state     <= st_dispatch;
			end
		end
	end

	// capture byte with its channel tag
	always_ff @(posedge clock) begin
		if (take) begin
			sample <= '{channel: channel, data: adc_data};
		end
	end

endmodule

// File: design/serial_pkg.sv
/*
 * Serial-link definitions: lane count, bit timing, frame length and the
 * per-lane status strobes. Shared by the lanes, the collector and the
 * sequencer's lane decode.
 */

package serial_pkg;

	// identical transmit lanes, picked by the low channel bits
	localparam int num_lanes = 4;

	// clocks per serial bit
	// kept short so a frame fits in a short simulation
	localparam int bit_cycles = 8;

	// start bit, eight data bits, stop bit
	localparam int frame_bits = 10;

	// one-cycle strobes from a lane
	// frame_done marks the last clock of the stop bit
	typedef struct packed {
		logic frame_done;
		logic overrun;
		logic no_dsr;
	} lane_status_t;

	// one bit per lane, bit i belongs to lane i
	typedef logic [num_lanes-1:0] lane_mask_t;

endpackage

// File: design/acq_pkg.sv
/*
 * Acquisition-side definitions: multiplexer channel count, channel index,
 * settle time and the captured sample word. Modules take it by a wildcard
 * import in the body; port lists use scoped names.
 */

package acq_pkg;

	// inputs on the external analog multiplexer
	localparam int num_channels = 8;

	// channel index as driven onto the mux address pins
	typedef logic [$clog2(num_channels)-1:0] channel_t;

	// clocks mux_en is held before soc is raised
	// covers mux switching plus ADC input track time
	localparam int mux_settle_cycles = 2;

	// one converted byte, tagged with the channel it was taken from
	// channel is kept so the lane can be chosen after capture
	typedef struct packed {
		channel_t   channel;
		logic [7:0] data;
	} sample_t;

endpackage
